/* common/sdInitPkg.sv */
package sdInitPkg;

    // ========================================
    // Sequencer states
    // ========================================
    typedef enum logic [3:0] {
        StGoIdle,       // CMD0
        StIfCond,       // CMD8
        StAppOpCond,    // CMD55 ahead of ACMD41
        StOpCond,       // ACMD41
        StCid,          // CMD2
        StRca,          // CMD3
        StSelect,       // CMD7
        StAppBus,       // CMD55 ahead of ACMD6
        StBusWidth,     // ACMD6
        StSendWait,     // Command frame going out
        StRespWait,     // Response coming in
        StGap,          // Idle clocks before the next command
        StDone
    } initStateT;

    // 12 MHz clk down to 400 kHz SD clock
    localparam int ClkHalfPeriod = 15;
    localparam int ClkCntWidth = $clog2(ClkHalfPeriod);

    // N_CC and N_RC minimum
    localparam int GapCycles = 8;
    localparam int GapCntWidth = $clog2(GapCycles + 1);

endpackage

/* common/sdProtoPkg.sv */
package sdProtoPkg;

    // ========================================
    // Command indices
    // ========================================
    typedef enum logic [5:0] {
        CmdGoIdle      = 6'd0,    // GO_IDLE_STATE
        CmdAllSendCid  = 6'd2,    // ALL_SEND_CID
        CmdSendRca     = 6'd3,    // SEND_RELATIVE_ADDR
        CmdSetBusWidth = 6'd6,    // SET_BUS_WIDTH, sent after APP_CMD
        CmdSelect      = 6'd7,    // SELECT_CARD
        CmdSendIfCond  = 6'd8,    // SEND_IF_COND
        CmdSendOpCond  = 6'd41,   // SD_SEND_OP_COND, sent after APP_CMD
        CmdAppCmd      = 6'd55    // APP_CMD
    } cmdIndexT;

    // Expected response per command
    typedef enum logic [1:0] {
        RespNone,    // No response at all
        RespR48,     // Short response with CRC7
        RespR3,      // Short response, index and CRC fields all ones
        RespR136     // Long CID response, CRC not checked
    } respKindT;

    // Frame lengths in bits
    localparam int CmdFrameBits = 48;
    localparam int LongRespBits = 136;

    // Pattern echoed back by CMD8
    localparam logic [7:0] CheckPattern = 8'hAA;
    // Supply voltage 2.7-3.6 V plus check pattern
    localparam logic [31:0] IfCondArg = {20'h00000, 4'h1, CheckPattern};
    // HCS and XPC set, 2.7-2.8 V window
    localparam logic [31:0] OpCondArg = 32'h5000_8000;
    // Four data lines
    localparam logic [31:0] BusWidth4Arg = 32'h0000_0002;

endpackage

/* dv/sdCardInitTb.sv */
`timescale 1ns/1ps

module sdCardInitTb;

    localparam int MaxCases     = 16;
    localparam int FaultNone    = 0;
    localparam int FaultCrc     = 1;
    localparam int FaultPattern = 2;
    localparam int StartTimeout = 200;
    localparam int ResetTimeout = 50;
    localparam int DoneTimeout  = 2000;
    localparam int HoldClocks   = 30;
    localparam logic [31:0] R1Status = 32'h0000_0920;

    logic        clk;
    logic        rstN;
    logic        rstReq;
    logic        sdClk;
    logic        sdCmdIn;
    logic        sdCmdOut;
    logic        sdCmdOutEn;
    logic [15:0] rca;
    logic        done;

    // Four words per case
    logic [15:0] caseMem [0:4*MaxCases-1];
    integer      seed;
    int          valueErrors;
    int          otherErrors;
    int          caseIdx;
    logic        firstCmd;

    // SD clock half period monitor
    int          halfClocks;
    logic        halfSeen;
    logic        sdClkLast;

    tbClkGen clkGen (
        .rstReq (rstReq),
        .clk    (clk),
        .rstN   (rstN)
    );

    sdCardInit sdCardInit_inst (
        .clk        (clk),
        .rstN       (rstN),
        .sdClk      (sdClk),
        .sdCmdIn    (sdCmdIn),
        .sdCmdOut   (sdCmdOut),
        .sdCmdOutEn (sdCmdOutEn),
        .rca        (rca),
        .done       (done)
    );

    // ========================================
    // Compare tasks
    // ========================================
    task checkCmd(input sdProtoPkg::cmdIndexT gotIdx, input logic [31:0] gotArg,
                  input sdProtoPkg::cmdIndexT expIdx, input logic [31:0] expArg);
        if (gotIdx !== expIdx) begin
            $display("FAIL cmdIndex got %h expected %h", gotIdx, expIdx);
            valueErrors++;
        end
        if (gotArg !== expArg) begin
            $display("FAIL cmdArg got %h expected %h", gotArg, expArg);
            valueErrors++;
        end
    endtask

    task checkRca(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAIL rca got %h expected %h", got, exp);
            valueErrors++;
        end
    endtask

    task checkCrc(input logic [6:0] got, input logic [6:0] exp);
        if (got !== exp) begin
            $display("FAIL crc7 got %h expected %h", got, exp);
            valueErrors++;
        end
    endtask

    task checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            valueErrors++;
        end
    endtask

    task checkHalfPeriod(input int got, input int exp);
        if (got != exp) begin
            $display("FAIL sdClk half period got %h expected %h", got, exp);
            valueErrors++;
        end
    endtask

    // CRC7 of 40 bits MSB first with generator x^7 + x^3 + 1
    function automatic logic [6:0] crc7Of(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    // ========================================
    // Run control
    // ========================================
    task finishRun;
        otherErrors += sdCardInit_inst.assertInst.failCount;
        $display("Summary: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task timeoutAbort(input string what);
        $display("ERROR: timeout, %s", what);
        otherErrors++;
        finishRun();
    endtask

    // Counts clk cycles between sdClk changes, from the first change after reset
    always @(negedge clk) begin
        if (rstN !== 1'b1) begin
            halfSeen   = 1'b0;
            halfClocks = 0;
        end else if (sdClk !== sdClkLast) begin
            if (halfSeen) begin
                checkHalfPeriod(halfClocks, sdInitPkg::ClkHalfPeriod);
            end
            halfSeen   = 1'b1;
            halfClocks = 1;
        end else begin
            halfClocks++;
        end
        sdClkLast = sdClk;
    end

    // ========================================
    // Card model
    // ========================================
    // Waits for a start bit, takes the frame at sdClk rises and checks it
    task expectCommand(input sdProtoPkg::cmdIndexT expIdx, input logic [31:0] expArg);
        logic [47:0] frame;
        logic        seen;
        int          idle;
        seen = 1'b0;
        idle = 0;
        while (!seen && idle < StartTimeout) begin
            @(posedge sdClk);
            if (sdCmdOutEn && !sdCmdOut) begin
                seen = 1'b1;
            end else begin
                idle++;
            end
        end
        if (!seen) begin
            timeoutAbort("no command start bit on the CMD line");
        end
        frame[47] = 1'b0;
        for (int i = 46; i >= 0; i--) begin
            @(posedge sdClk);
            frame[i] = sdCmdOut;
        end
        #1;
        checkBit("transmission bit", frame[46], 1'b1);
        checkBit("end bit", frame[0], 1'b1);
        checkCrc(frame[7:1], crc7Of(frame[47:8]));
        checkCmd(sdProtoPkg::cmdIndexT'(frame[45:40]), frame[39:8], expIdx, expArg);
        // Still initializing while commands go out
        checkBit("done", done, 1'b0);
        if (!firstCmd && idle < sdInitPkg::GapCycles) begin
            $display("ERROR: only %0d idle SD clocks before CMD%0d", idle, expIdx);
            otherErrors++;
        end
        firstCmd = 1'b0;
    endtask

    // Drives each bit MSB first a little after an sdClk fall
    task sendResponse(input logic [135:0] bits, input int len);
        // Command end plus two SD clocks of turnaround
        repeat (3) @(negedge sdClk);
        for (int i = len - 1; i >= 0; i--) begin
            #1;
            sdCmdIn = bits[i];
            @(negedge sdClk);
        end
        #1;
        sdCmdIn = 1'b1;
    endtask

    task sendShort(input sdProtoPkg::cmdIndexT idx, input logic [31:0] payload,
                   input logic badCrc);
        logic [39:0] head;
        logic [6:0]  crc;
        head = {2'b00, idx, payload};
        crc  = crc7Of(head);
        if (badCrc) begin
            crc = ~crc;
        end
        sendResponse({head, crc, 1'b1}, 48);
    endtask

    // One pass from CMD0 that sets restarted when the card faulted
    task runPass(input int busyReplies, input logic [15:0] cardRca, input int fault,
                 output logic restarted);
        logic [127:0] cid;
        logic [31:0]  ocr;
        restarted = 1'b1;
        expectCommand(sdProtoPkg::CmdGoIdle, 32'h0);
        expectCommand(sdProtoPkg::CmdSendIfCond, sdProtoPkg::IfCondArg);
        if (fault == FaultPattern) begin
            sendShort(sdProtoPkg::CmdSendIfCond, 32'h0000_0155, 1'b0);
        end else begin
            sendShort(sdProtoPkg::CmdSendIfCond, sdProtoPkg::IfCondArg, 1'b0);
            // Busy replies first, then ready
            for (int b = 0; b <= busyReplies; b++) begin
                expectCommand(sdProtoPkg::CmdAppCmd, 32'h0);
                sendShort(sdProtoPkg::CmdAppCmd, R1Status, 1'b0);
                expectCommand(sdProtoPkg::CmdSendOpCond, sdProtoPkg::OpCondArg);
                ocr = (b < busyReplies) ? 32'h00FF_8000 : 32'hC0FF_8000;
                sendResponse({2'b00, 6'h3F, ocr, 7'h7F, 1'b1}, 48);
            end
            expectCommand(sdProtoPkg::CmdAllSendCid, 32'h0);
            cid = {$random(seed), $random(seed), $random(seed), $random(seed)};
            sendResponse({2'b00, 6'h3F, cid[127:1], 1'b1}, 136);
            expectCommand(sdProtoPkg::CmdSendRca, 32'h0);
            sendShort(sdProtoPkg::CmdSendRca, {cardRca, 16'h0500}, fault == FaultCrc);
            if (fault != FaultCrc) begin
                expectCommand(sdProtoPkg::CmdSelect, {cardRca, 16'h0000});
                sendShort(sdProtoPkg::CmdSelect, R1Status, 1'b0);
                expectCommand(sdProtoPkg::CmdAppCmd, {cardRca, 16'h0000});
                sendShort(sdProtoPkg::CmdAppCmd, R1Status, 1'b0);
                expectCommand(sdProtoPkg::CmdSetBusWidth, sdProtoPkg::BusWidth4Arg);
                sendShort(sdProtoPkg::CmdSetBusWidth, R1Status, 1'b0);
                restarted = 1'b0;
            end
        end
    endtask

    task runCase(input int num);
        int          busyReplies;
        int          fault;
        int          passes;
        int          waitCnt;
        logic [15:0] cardRca;
        logic [15:0] expRca;
        logic        restarted;
        busyReplies = caseMem[4*num];
        cardRca     = caseMem[4*num+1];
        fault       = caseMem[4*num+2];
        expRca      = caseMem[4*num+3];
        $display("Case %0d: busy %0d rca %h fault %0d", num, busyReplies, cardRca, fault);
        // Power-on reset covers the first case
        if (num != 0) begin
            @(posedge clk);
            #1;
            rstReq = 1'b1;
            @(posedge clk);
            #1;
            rstReq = 1'b0;
        end
        waitCnt = 0;
        while (rstN !== 1'b1 && waitCnt < ResetTimeout) begin
            @(posedge clk);
            waitCnt++;
        end
        if (rstN !== 1'b1) begin
            timeoutAbort("reset was never released");
        end
        firstCmd  = 1'b1;
        passes    = 0;
        restarted = 1'b1;
        while (restarted && passes < 3) begin
            runPass(busyReplies, cardRca, fault, restarted);
            // Card misbehaves only once per case
            fault = FaultNone;
            passes++;
        end
        if (restarted) begin
            $display("ERROR: sequence did not complete after %0d passes", passes);
            otherErrors++;
        end else begin
            waitCnt = 0;
            while (!done && waitCnt < DoneTimeout) begin
                @(posedge clk);
                #1;
                waitCnt++;
            end
            if (!done) begin
                timeoutAbort("done never rose after the ACMD6 response");
            end
            checkRca(rca, expRca);
            // Idle and done from here on
            repeat (HoldClocks) begin
                @(posedge sdClk);
                #1;
                checkBit("done", done, 1'b1);
                checkBit("sdCmdOutEn", sdCmdOutEn, 1'b0);
            end
        end
    endtask

    // ========================================
    // Case loop
    // ========================================
    initial begin
        sdCmdIn     = 1'b1;
        rstReq      = 1'b0;
        seed        = 32'h3246_62ca;
        valueErrors = 0;
        otherErrors = 0;
        firstCmd    = 1'b1;
        $readmemh("dv/sdInitCases.txt", caseMem);
        caseIdx = 0;
        while (caseIdx < MaxCases && !$isunknown(caseMem[4*caseIdx])) begin
            runCase(caseIdx);
            caseIdx++;
        end
        if (caseIdx == 0) begin
            $display("ERROR: no cases were read from the case file");
            otherErrors++;
        end
        finishRun();
    end

endmodule

/* dv/sdCardInit_assert.sv */
`timescale 1ns/1ps

module sdCardInit_assert (
    input logic clk,
    input logic rstN,
    input logic sdFall,
    input logic cmdStart,
    input logic sdCmdOutEn,
    input logic done
);

    // Number of assertion failures so far
    int failCount = 0;

    // CMD driver enable only moves with an SD clock fall
    assert property (@(posedge clk) disable iff (!rstN)
                     $changed(sdCmdOutEn) |-> $past(sdFall))
        else begin
            failCount++;
            $error("sdCmdOutEn changed outside an SD clock fall");
        end

    // Once done, the initializer stays done until reset
    assert property (@(posedge clk) $fell(done) |-> !rstN)
        else begin
            failCount++;
            $error("done fell while reset was inactive");
        end

    // No new command while a frame is on the line
    assert property (@(posedge clk) disable iff (!rstN)
                     cmdStart |-> !sdCmdOutEn)
        else begin
            failCount++;
            $error("cmdStart given while the CMD line was driven");
        end

endmodule

bind sdCardInit sdCardInit_assert assertInst (
    .clk        (clk),
    .rstN       (rstN),
    .sdFall     (sdFall),
    .cmdStart   (cmdStart),
    .sdCmdOutEn (sdCmdOutEn),
    .done       (done)
);

/* dv/sdInitCases.txt */
// busyReplies  cardRca  fault  expectedRca  (all hex)
// fault 0 none, 1 bad CRC on the CMD3 response, 2 wrong CMD8 check pattern
0 0001 0 0001
1 1234 0 1234
3 B368 0 B368
2 FFFF 0 FFFF
0 8001 1 8001
2 4C2A 1 4C2A
1 0F0F 2 0F0F
4 7E5D 2 7E5D

/* dv/tbClkGen.sv */
`timescale 1ns/1ps

module tbClkGen (
    input  logic rstReq,
    output logic clk,
    output logic rstN
);

    // 100 MHz testbench clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 10 cycles at start and again on each request
    always begin
        rstN = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(posedge rstReq);
    end

endmodule

/* rtl/sdCardInit.sv */
`timescale 1ns/1ps

module sdCardInit (
    input  logic        clk,
    input  logic        rstN,
    output logic        sdClk,
    input  logic        sdCmdIn,
    output logic        sdCmdOut,
    output logic        sdCmdOutEn,
    output logic [15:0] rca,
    output logic        done
);

    // SD clock strobes
    logic sdRise;
    logic sdFall;

    // Controller to transmitter
    logic                 cmdStart;
    sdProtoPkg::cmdIndexT cmdIndex;
    logic [31:0]          cmdArg;
    logic                 cmdDone;

    // Controller to receiver
    logic                 respArm;
    sdProtoPkg::respKindT respKind;
    logic                 respDone;
    logic                 respOk;
    sdProtoPkg::cmdIndexT respIndex;
    logic [31:0]          respPayload;

    sdClkGen clkGen (
        .clk    (clk),
        .rstN   (rstN),
        .sdClk  (sdClk),
        .sdRise (sdRise),
        .sdFall (sdFall)
    );

    sdInitCtrl ctrl (
        .clk         (clk),
        .rstN        (rstN),
        .sdRise      (sdRise),
        .cmdDone     (cmdDone),
        .respDone    (respDone),
        .respOk      (respOk),
        .respIndex   (respIndex),
        .respPayload (respPayload),
        .cmdStart    (cmdStart),
        .cmdIndex    (cmdIndex),
        .cmdArg      (cmdArg),
        .respArm     (respArm),
        .respKind    (respKind),
        .rca         (rca),
        .done        (done)
    );

    // ========================================
    // CMD line datapath
    // ========================================
    sdCmdTx cmdTx (
        .clk        (clk),
        .rstN       (rstN),
        .sdFall     (sdFall),
        .cmdStart   (cmdStart),
        .cmdIndex   (cmdIndex),
        .cmdArg     (cmdArg),
        .sdCmdOut   (sdCmdOut),
        .sdCmdOutEn (sdCmdOutEn),
        .cmdDone    (cmdDone)
    );

    sdRespRx respRx (
        .clk         (clk),
        .rstN        (rstN),
        .sdRise      (sdRise),
        .sdCmdIn     (sdCmdIn),
        .respArm     (respArm),
        .respKind    (respKind),
        .respDone    (respDone),
        .respOk      (respOk),
        .respIndex   (respIndex),
        .respPayload (respPayload)
    );

endmodule

/* rtl/sdClkGen.sv */
`timescale 1ns/1ps

module sdClkGen (
    input  logic clk,
    input  logic rstN,
    output logic sdClk,
    output logic sdRise,
    output logic sdFall
);

    logic [sdInitPkg::ClkCntWidth-1:0] halfCnt;
    logic halfEnd;

    // Last clk cycle of a half period
    assign halfEnd = (halfCnt == '0);

    // Strobes lead the matching sdClk edge by one clk cycle
    assign sdRise = halfEnd && !sdClk;
    assign sdFall = halfEnd && sdClk;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            halfCnt <= sdInitPkg::ClkCntWidth'(sdInitPkg::ClkHalfPeriod - 1);
            sdClk   <= 1'b0;
        end else if (halfEnd) begin
            halfCnt <= sdInitPkg::ClkCntWidth'(sdInitPkg::ClkHalfPeriod - 1);
            sdClk   <= !sdClk;
        end else begin
            halfCnt <= halfCnt - 1'b1;
        end
    end

endmodule

/* rtl/sdInitCtrl.sv */
`timescale 1ns/1ps

module sdInitCtrl (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 sdRise,
    input  logic                 cmdDone,
    input  logic                 respDone,
    input  logic                 respOk,
    input  sdProtoPkg::cmdIndexT respIndex,
    input  logic [31:0]          respPayload,
    output logic                 cmdStart,
    output sdProtoPkg::cmdIndexT cmdIndex,
    output logic [31:0]          cmdArg,
    output logic                 respArm,
    output sdProtoPkg::respKindT respKind,
    output logic [15:0]          rca,
    output logic                 done
);

    sdInitPkg::initStateT state;
    sdInitPkg::initStateT retState;

    // Decoded command for the current command state
    sdInitPkg::initStateT nxtRet;
    sdProtoPkg::cmdIndexT nxtIndex;
    sdProtoPkg::respKindT nxtKind;
    logic [31:0]          nxtArg;

    logic [sdInitPkg::GapCntWidth-1:0] gapCnt;
    logic [31:0] rcaArg;
    logic indexOk;
    logic patternOk;
    logic respGood;

    // RCA in the upper half, stuff bits below
    assign rcaArg = {rca, 16'h0000};

    // ========================================
    // Command table
    // ========================================
    always_comb begin
        nxtIndex = sdProtoPkg::CmdGoIdle;
        nxtArg   = '0;
        nxtKind  = sdProtoPkg::RespR48;
        nxtRet   = sdInitPkg::StDone;
        case (state)
            sdInitPkg::StGoIdle: begin
                nxtKind = sdProtoPkg::RespNone;
                nxtRet  = sdInitPkg::StIfCond;
            end
            sdInitPkg::StIfCond: begin
                nxtIndex = sdProtoPkg::CmdSendIfCond;
                nxtArg   = sdProtoPkg::IfCondArg;
                nxtRet   = sdInitPkg::StAppOpCond;
            end
            sdInitPkg::StAppOpCond: begin
                // rca is still zero here
                nxtIndex = sdProtoPkg::CmdAppCmd;
                nxtArg   = rcaArg;
                nxtRet   = sdInitPkg::StOpCond;
            end
            sdInitPkg::StOpCond: begin
                nxtIndex = sdProtoPkg::CmdSendOpCond;
                nxtArg   = sdProtoPkg::OpCondArg;
                nxtKind  = sdProtoPkg::RespR3;
                nxtRet   = sdInitPkg::StCid;
            end
            sdInitPkg::StCid: begin
                nxtIndex = sdProtoPkg::CmdAllSendCid;
                nxtKind  = sdProtoPkg::RespR136;
                nxtRet   = sdInitPkg::StRca;
            end
            sdInitPkg::StRca: begin
                nxtIndex = sdProtoPkg::CmdSendRca;
                nxtRet   = sdInitPkg::StSelect;
            end
            sdInitPkg::StSelect: begin
                nxtIndex = sdProtoPkg::CmdSelect;
                nxtArg   = rcaArg;
                nxtRet   = sdInitPkg::StAppBus;
            end
            sdInitPkg::StAppBus: begin
                nxtIndex = sdProtoPkg::CmdAppCmd;
                nxtArg   = rcaArg;
                nxtRet   = sdInitPkg::StBusWidth;
            end
            sdInitPkg::StBusWidth: begin
                nxtIndex = sdProtoPkg::CmdSetBusWidth;
                nxtArg   = sdProtoPkg::BusWidth4Arg;
            end
            default: begin
            end
        endcase
    end

    // Short responses other than R3 echo the command index
    assign indexOk = (respKind != sdProtoPkg::RespR48) || (respIndex == cmdIndex);
    // CMD8 must return our pattern
    assign patternOk = (cmdIndex != sdProtoPkg::CmdSendIfCond) ||
                       (respPayload[7:0] == sdProtoPkg::CheckPattern);
    assign respGood = respOk && indexOk && patternOk;

    // Receiver is armed as the command's end bit finishes
    assign respArm = (state == sdInitPkg::StSendWait) && cmdDone &&
                     (respKind != sdProtoPkg::RespNone);
    assign done = (state == sdInitPkg::StDone);

    // ========================================
    // Sequencer
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= sdInitPkg::StGoIdle;
            retState <= sdInitPkg::StGoIdle;
            cmdStart <= 1'b0;
            cmdIndex <= sdProtoPkg::CmdGoIdle;
            cmdArg   <= '0;
            respKind <= sdProtoPkg::RespNone;
            gapCnt   <= '0;
            rca      <= '0;
        end else begin
            cmdStart <= 1'b0;
            case (state)
                sdInitPkg::StSendWait: begin
                    if (cmdDone && respKind == sdProtoPkg::RespNone) begin
                        gapCnt <= sdInitPkg::GapCntWidth'(sdInitPkg::GapCycles);
                        state  <= sdInitPkg::StGap;
                    end else if (cmdDone) begin
                        state <= sdInitPkg::StRespWait;
                    end
                end
                sdInitPkg::StRespWait: begin
                    if (respDone) begin
                        gapCnt <= sdInitPkg::GapCntWidth'(sdInitPkg::GapCycles);
                        state  <= sdInitPkg::StGap;
                        // Any bad response restarts from CMD0
                        if (!respGood) begin
                            retState <= sdInitPkg::StGoIdle;
                        end else if (cmdIndex == sdProtoPkg::CmdSendOpCond &&
                                     !respPayload[31]) begin
                            // Card still busy, repeat ACMD41
                            retState <= sdInitPkg::StAppOpCond;
                        end else if (cmdIndex == sdProtoPkg::CmdSendRca) begin
                            rca <= respPayload[31:16];
                        end
                    end
                end
                sdInitPkg::StGap: begin
                    if (sdRise && gapCnt == sdInitPkg::GapCntWidth'(1)) begin
                        state <= retState;
                    end else if (sdRise) begin
                        gapCnt <= gapCnt - 1'b1;
                    end
                end
                sdInitPkg::StDone: begin
                end
                default: begin
                    // Command states issue their frame here
                    cmdStart <= 1'b1;
                    cmdIndex <= nxtIndex;
                    cmdArg   <= nxtArg;
                    respKind <= nxtKind;
                    retState <= nxtRet;
                    state    <= sdInitPkg::StSendWait;
                    if (state == sdInitPkg::StGoIdle) begin
                        rca <= '0;
                    end
                end
            endcase
        end
    end

endmodule

/* sdCardInit.f */
common/sdProtoPkg.sv
common/sdInitPkg.sv
sdCmd/sdCrc7.sv
sdCmd/sdCmdTx.sv
sdCmd/sdRespRx.sv
rtl/sdClkGen.sv
rtl/sdInitCtrl.sv
rtl/sdCardInit.sv
dv/tbClkGen.sv
dv/sdCardInit_assert.sv
dv/sdCardInitTb.sv

/* sdCmd/sdCmdTx.sv */
`timescale 1ns/1ps

module sdCmdTx (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 sdFall,
    input  logic                 cmdStart,
    input  sdProtoPkg::cmdIndexT cmdIndex,
    input  logic [31:0]          cmdArg,
    output logic                 sdCmdOut,
    output logic                 sdCmdOutEn,
    output logic                 cmdDone
);

    logic [sdProtoPkg::CmdFrameBits-1:0] shiftReg;
    logic [5:0] bitCnt;
    logic       busy;
    logic [6:0] crc;
    logic       crcEn;
    logic       crcSlot;

    // CRC covers start, transmission, index and argument bits
    assign crcEn = sdFall && busy && (bitCnt < 6'(sdProtoPkg::CmdFrameBits - 8));
    // First 40 bits sent, CRC field is next in line
    assign crcSlot = busy && (bitCnt == 6'(sdProtoPkg::CmdFrameBits - 8));

    sdCrc7 crcGen (
        .clk   (clk),
        .rstN  (rstN),
        .clear (cmdStart),
        .bitEn (crcEn),
        .bitIn (shiftReg[sdProtoPkg::CmdFrameBits-1]),
        .crc   (crc)
    );

    // Frame shifter, MSB first, CRC patched in between two falls
    always_ff @(posedge clk) begin
        if (cmdStart) begin
            shiftReg <= {2'b01, cmdIndex, cmdArg, 7'h00, 1'b1};
        end else if (busy && sdFall) begin
            shiftReg <= {shiftReg[sdProtoPkg::CmdFrameBits-2:0], 1'b1};
        end else if (crcSlot) begin
            shiftReg[sdProtoPkg::CmdFrameBits-1 -: 7] <= crc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy       <= 1'b0;
            bitCnt     <= '0;
            sdCmdOut   <= 1'b1;
            sdCmdOutEn <= 1'b0;
            cmdDone    <= 1'b0;
        end else begin
            cmdDone <= 1'b0;
            if (cmdStart) begin
                busy   <= 1'b1;
                bitCnt <= '0;
            end else if (busy && sdFall) begin
                if (bitCnt == 6'(sdProtoPkg::CmdFrameBits)) begin
                    // End bit has had its full SD clock
                    busy       <= 1'b0;
                    sdCmdOut   <= 1'b1;
                    sdCmdOutEn <= 1'b0;
                    cmdDone    <= 1'b1;
                end else begin
                    sdCmdOutEn <= 1'b1;
                    sdCmdOut   <= shiftReg[sdProtoPkg::CmdFrameBits-1];
                    bitCnt     <= bitCnt + 1'b1;
                end
            end
        end
    end

endmodule

/* sdCmd/sdCrc7.sv */
`timescale 1ns/1ps

module sdCrc7 (
    input  logic       clk,
    input  logic       rstN,
    input  logic       clear,
    input  logic       bitEn,
    input  logic       bitIn,
    output logic [6:0] crc
);

    logic feedback;

    // x^7 + x^3 + 1, data enters MSB first
    assign feedback = bitIn ^ crc[6];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (bitEn) begin
            crc <= {crc[5:0], 1'b0} ^ {3'b000, feedback, 2'b00, feedback};
        end
    end

endmodule

/* sdCmd/sdRespRx.sv */
`timescale 1ns/1ps

module sdRespRx (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 sdRise,
    input  logic                 sdCmdIn,
    input  logic                 respArm,
    input  sdProtoPkg::respKindT respKind,
    output logic                 respDone,
    output logic                 respOk,
    output sdProtoPkg::cmdIndexT respIndex,
    output logic [31:0]          respPayload
);

    logic [1:0] cmdSync;
    logic       armed;
    logic [7:0] bitCnt;
    logic       txBit;
    logic       takeBit;
    logic       lastBit;
    logic       crcEn;
    logic       fieldsOk;
    logic [6:0] crc;
    logic [sdProtoPkg::CmdFrameBits-1:0] window;
    sdProtoPkg::respKindT kind;

    // Line idles high, the first low sample is the start bit
    assign takeBit = sdRise && armed && (bitCnt != 8'd0 || !cmdSync[1]);
    assign lastBit = (kind == sdProtoPkg::RespR136) ?
                     (bitCnt == 8'(sdProtoPkg::LongRespBits - 1)) :
                     (bitCnt == 8'(sdProtoPkg::CmdFrameBits - 1));
    assign crcEn = takeBit && (bitCnt < 8'(sdProtoPkg::CmdFrameBits - 8));

    sdCrc7 crcChk (
        .clk   (clk),
        .rstN  (rstN),
        .clear (respArm),
        .bitEn (crcEn),
        .bitIn (cmdSync[1]),
        .crc   (crc)
    );

    // Two-flop synchronizer on the card's CMD output
    always_ff @(posedge clk) begin
        if (!rstN) begin
            cmdSync <= 2'b11;
        end else begin
            cmdSync <= {cmdSync[0], sdCmdIn};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            armed    <= 1'b0;
            bitCnt   <= '0;
            kind     <= sdProtoPkg::RespNone;
            respDone <= 1'b0;
        end else begin
            respDone <= 1'b0;
            if (respArm) begin
                armed  <= 1'b1;
                bitCnt <= '0;
                kind   <= respKind;
            end else if (takeBit && lastBit) begin
                armed    <= 1'b0;
                bitCnt   <= '0;
                respDone <= 1'b1;
            end else if (takeBit) begin
                bitCnt <= bitCnt + 1'b1;
            end
        end
    end

    // Last 48 bits kept, transmission bit captured on its own for R2
    always_ff @(posedge clk) begin
        if (takeBit) begin
            window <= {window[sdProtoPkg::CmdFrameBits-2:0], cmdSync[1]};
            if (bitCnt == 8'd1) begin
                txBit <= cmdSync[1];
            end
        end
    end

    // ========================================
    // Response checks
    // ========================================
    always_comb begin
        case (kind)
            sdProtoPkg::RespR48: fieldsOk = (window[7:1] == crc);
            sdProtoPkg::RespR3:  fieldsOk = (&window[45:40]) && (&window[7:1]);
            default:             fieldsOk = 1'b1;
        endcase
    end

    assign respOk      = fieldsOk && !txBit && window[0];
    assign respIndex   = sdProtoPkg::cmdIndexT'(window[45:40]);
    assign respPayload = window[39:8];

endmodule
